// ==== include/conv_cfg.svh ====
`ifndef CONV_CFG_SVH
`define CONV_CFG_SVH

// matrix geometry
`define CONV_ENTRIES 16
`define CONV_IDX_W   4

// data, filter and result width
`define CONV_WORD_W  32

// custom-0 major opcode
`define CONV_OPCODE  7'b0001011

`endif

// ==== hdl/conv_pkg.sv ====
`include "conv_cfg.svh"

package conv_pkg;

   // funct7 values of the custom instruction
   typedef enum logic [2:0] {
      op_none         = 3'd0,
      op_filter_1     = 3'd1,
      op_filter_2     = 3'd2,
      op_data_1       = 3'd3,
      op_data_2       = 3'd4,
      op_filter_clear = 3'd5,
      op_data_clear   = 3'd6,
      op_run          = 3'd7
   } conv_op_e;

   // one decoded command, every strobe is a single-cycle pulse
   typedef struct packed {
      logic                       filter_wr;
      logic                       data_wr;
      logic                       pair;       // rs2 is written as well
      logic [2*`CONV_WORD_W-1:0]  wdata;      // {rs2, rs1}
      logic                       filter_clr;
      logic                       data_clr;
      logic                       run;
   } conv_cmd_t;

   typedef struct packed {
      logic [`CONV_ENTRIES-1:0] full;  // one flag per entry
      logic [`CONV_WORD_W-1:0]  word;  // entry at the engine index
   } buf_status_t;

endpackage

// ==== hdl/conv_decoder.sv ====
`timescale 1ns/1ns
`include "conv_cfg.svh"

module conv_decoder (
   input  logic                     clk_i,
   input  logic                     rst_i,
   input  logic                     instr_valid_i,
   input  logic [31:0]              instr_i,
   input  logic [`CONV_WORD_W-1:0]  rs1_i,
   input  logic [`CONV_WORD_W-1:0]  rs2_i,
   output conv_pkg::conv_cmd_t      cmd_o
);

   logic [6:0]          opcode;
   logic [6:0]          funct7;
   logic                is_custom;
   conv_pkg::conv_op_e  op;
   conv_pkg::conv_cmd_t cmd_next;

   assign opcode    = instr_i[6:0];
   assign funct7    = instr_i[31:25];
   assign is_custom = instr_valid_i && (opcode == `CONV_OPCODE);

   // only funct7 0..7 are defined, the rest decode to no operation
   always_comb begin
      op = conv_pkg::op_none;
      if (is_custom && (funct7[6:3] == 4'd0)) begin
         op = conv_pkg::conv_op_e'(funct7[2:0]);
      end
   end

   always_comb begin
      cmd_next = '0;
      case (op)
         conv_pkg::op_filter_1: begin
            cmd_next.filter_wr = 1'b1;
            cmd_next.wdata     = {rs2_i, rs1_i};
         end
         conv_pkg::op_filter_2: begin
            cmd_next.filter_wr = 1'b1;
            cmd_next.pair      = 1'b1;
            cmd_next.wdata     = {rs2_i, rs1_i};
         end
         conv_pkg::op_data_1: begin
            cmd_next.data_wr = 1'b1;
            cmd_next.wdata   = {rs2_i, rs1_i};
         end
         conv_pkg::op_data_2: begin
            cmd_next.data_wr = 1'b1;
            cmd_next.pair    = 1'b1;
            cmd_next.wdata   = {rs2_i, rs1_i};
         end
         conv_pkg::op_filter_clear: begin
            cmd_next.filter_clr = 1'b1;
         end
         conv_pkg::op_data_clear: begin
            cmd_next.data_clr = 1'b1;
         end
         conv_pkg::op_run: begin
            cmd_next.run = 1'b1;
         end
         default: begin
            cmd_next = '0;
         end
      endcase
   end

   // one cycle of decode latency, no hold here so clears always pass
   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         cmd_o <= '0;
      end else begin
         cmd_o <= cmd_next;
      end
   end

endmodule

// ==== hdl/matrix_buffer.sv ====
`timescale 1ns/1ns
`include "conv_cfg.svh"

module matrix_buffer (
   input  logic                       clk_i,
   input  logic                       rst_i,
   input  logic                       hold_i,
   input  logic                       wr_i,
   input  logic                       pair_i,
   input  logic                       clear_i,
   input  logic                       lock_i,
   input  logic [2*`CONV_WORD_W-1:0]  wdata_i,
   input  logic [`CONV_IDX_W-1:0]     rd_idx_i,
   output conv_pkg::buf_status_t      status_o
);

   logic [`CONV_WORD_W-1:0]  mem [`CONV_ENTRIES];
   logic [`CONV_IDX_W-1:0]   wr_ptr;
   logic [`CONV_IDX_W-1:0]   ptr_plus1;
   logic [`CONV_ENTRIES-1:0] full;
   logic [`CONV_WORD_W-1:0]  wd_lo;
   logic [`CONV_WORD_W-1:0]  wd_hi;
   logic                     wr_en;

   assign wd_lo     = wdata_i[`CONV_WORD_W-1:0];               // rs1
   assign wd_hi     = wdata_i[2*`CONV_WORD_W-1:`CONV_WORD_W];  // rs2
   assign ptr_plus1 = wr_ptr + 1'b1;                           // wraps 15 -> 0
   assign wr_en     = wr_i && !lock_i && !hold_i && !clear_i;

   // pointer and flags, clear acts even while held
   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         wr_ptr <= '0;
         full   <= '0;
      end else if (clear_i) begin
         wr_ptr <= '0;
         full   <= '0;
      end else if (wr_en) begin
         full[wr_ptr] <= 1'b1;
         if (pair_i) begin
            full[ptr_plus1] <= 1'b1;
            wr_ptr          <= wr_ptr + `CONV_IDX_W'(2);
         end else begin
            wr_ptr <= ptr_plus1;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (wr_en) begin
         mem[wr_ptr] <= wd_lo;
         if (pair_i) begin
            mem[ptr_plus1] <= wd_hi;
         end
      end
   end

   assign status_o.full = full;
   assign status_o.word = mem[rd_idx_i];  // async read for the engine

endmodule

// ==== hdl/mac_engine.sv ====
`timescale 1ns/1ns
`include "conv_cfg.svh"

module mac_engine (
   input  logic                     clk_i,
   input  logic                     rst_i,
   input  logic                     hold_i,
   input  logic                     clear_i,
   input  conv_pkg::buf_status_t    filter_i,
   input  conv_pkg::buf_status_t    data_i,
   output logic [`CONV_IDX_W-1:0]   rd_idx_o,
   output logic [`CONV_WORD_W-1:0]  sum_o,
   output logic                     done_o,
   output logic                     pair_ready_o,
   output logic                     busy_o
);

   logic [`CONV_IDX_W-1:0]   idx;
   logic                     acc_phase;  // product is waiting to be added
   logic [`CONV_WORD_W-1:0]  product;
   logic [`CONV_WORD_W-1:0]  sum;
   logic                     done;
   logic [`CONV_ENTRIES-1:0] both_full;
   logic                     last_entry;

   assign both_full    = filter_i.full & data_i.full;
   assign pair_ready_o = both_full[idx];
   assign last_entry   = (idx == `CONV_IDX_W'(`CONV_ENTRIES - 1));

   // work remains and can go ahead this cycle
   assign busy_o = !done && (acc_phase || pair_ready_o);

   // phase control, index and sum
   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         idx       <= '0;
         acc_phase <= 1'b0;
         sum       <= '0;
         done      <= 1'b0;
      end else if (clear_i) begin
         idx       <= '0;
         acc_phase <= 1'b0;
         sum       <= '0;
         done      <= 1'b0;
      end else if (!hold_i) begin
         if (acc_phase) begin
            sum       <= sum + product;  // wraps modulo 2^32
            idx       <= idx + 1'b1;
            acc_phase <= 1'b0;
            if (last_entry) begin
               done <= 1'b1;
            end
         end else if (busy_o) begin
            acc_phase <= 1'b1;
         end
      end
   end

   // multiply phase, low 32 bits of the product only
   always_ff @(posedge clk_i) begin
      if (!hold_i && !acc_phase && busy_o) begin
         product <= filter_i.word * data_i.word;
      end
   end

   assign rd_idx_o = idx;
   assign sum_o    = sum;
   assign done_o   = done;

endmodule

// ==== hdl/conv_responder.sv ====
`timescale 1ns/1ns
`include "conv_cfg.svh"

module conv_responder (
   input  logic                     clk_i,
   input  logic                     rst_i,
   input  logic                     hold_i,
   input  logic                     run_i,
   input  logic                     clear_i,
   input  logic                     done_i,
   input  logic                     pair_ready_i,
   input  logic [`CONV_WORD_W-1:0]  sum_i,
   output logic                     stall_o,
   output logic                     ready_o,
   output logic [`CONV_WORD_W-1:0]  result_o
);

   logic answer_now;
   logic stall_release;
   logic take_result;

   // done, or stuck on an unfilled pair: answer at once
   assign answer_now    = run_i && (done_i || !pair_ready_i);
   assign stall_release = stall_o && done_i;
   assign take_result   = answer_now || stall_release;

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         stall_o  <= 1'b0;
         ready_o  <= 1'b0;
         result_o <= '0;
      end else if (clear_i) begin
         // engine restarts, a pending run is dropped
         stall_o <= 1'b0;
         ready_o <= 1'b0;
      end else if (hold_i) begin
         ready_o <= 1'b0;  // stall and result stay frozen
      end else begin
         ready_o <= take_result;
         if (take_result) begin
            result_o <= sum_i;
         end
         if (stall_release) begin
            stall_o <= 1'b0;
         end else if (run_i && !answer_now) begin
            stall_o <= 1'b1;  // held until the last accumulate
         end
      end
   end

endmodule

// ==== hdl/conv_accel_top.sv ====
`timescale 1ns/1ns
`include "conv_cfg.svh"

module conv_accel_top (
   input  logic                     clk_i,
   input  logic                     rst_i,
   input  logic                     hold_i,
   input  logic                     instr_valid_i,
   input  logic [31:0]              instr_i,
   input  logic [`CONV_WORD_W-1:0]  rs1_i,
   input  logic [`CONV_WORD_W-1:0]  rs2_i,
   output logic                     stall_o,
   output logic                     ready_o,
   output logic [`CONV_WORD_W-1:0]  result_o
);

   conv_pkg::conv_cmd_t     cmd;
   conv_pkg::buf_status_t   filter_status;
   conv_pkg::buf_status_t   data_status;
   logic [`CONV_IDX_W-1:0]  rd_idx;
   logic [`CONV_WORD_W-1:0] sum;
   logic                    done;
   logic                    pair_ready;
   logic                    any_clear;

   // either clear restarts the sum
   assign any_clear = cmd.filter_clr | cmd.data_clr;

   conv_decoder u_decoder (
      .clk_i         (clk_i),
      .rst_i         (rst_i),
      .instr_valid_i (instr_valid_i),
      .instr_i       (instr_i),
      .rs1_i         (rs1_i),
      .rs2_i         (rs2_i),
      .cmd_o         (cmd)
   );

   matrix_buffer u_filter_buf (
      .clk_i    (clk_i),
      .rst_i    (rst_i),
      .hold_i   (hold_i),
      .wr_i     (cmd.filter_wr),
      .pair_i   (cmd.pair),
      .clear_i  (cmd.filter_clr),
      .lock_i   (done),
      .wdata_i  (cmd.wdata),
      .rd_idx_i (rd_idx),
      .status_o (filter_status)
   );

   matrix_buffer u_data_buf (
      .clk_i    (clk_i),
      .rst_i    (rst_i),
      .hold_i   (hold_i),
      .wr_i     (cmd.data_wr),
      .pair_i   (cmd.pair),
      .clear_i  (cmd.data_clr),
      .lock_i   (done),
      .wdata_i  (cmd.wdata),
      .rd_idx_i (rd_idx),
      .status_o (data_status)
   );

   mac_engine u_engine (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .hold_i       (hold_i),
      .clear_i      (any_clear),
      .filter_i     (filter_status),
      .data_i       (data_status),
      .rd_idx_o     (rd_idx),
      .sum_o        (sum),
      .done_o       (done),
      .pair_ready_o (pair_ready),
      .busy_o       ()
   );

   conv_responder u_responder (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .hold_i       (hold_i),
      .run_i        (cmd.run),
      .clear_i      (any_clear),
      .done_i       (done),
      .pair_ready_i (pair_ready),
      .sum_i        (sum),
      .stall_o      (stall_o),
      .ready_o      (ready_o),
      .result_o     (result_o)
   );

endmodule

// ==== sim/conv_accel_sva.sv ====
`timescale 1ns/1ns

module conv_accel_sva (
   input logic clk_i,
   input logic rst_i,
   input logic clear_i,
   input logic stall_i,
   input logic ready_i
);

   // a run gets either a stall or an answer, never both
   a_stall_ready_excl : assert property (@(posedge clk_i) disable iff (!rst_i)
      !(stall_i && ready_i))
      else $error("stall_o and ready_o high in the same cycle");

   a_ready_pulse : assert property (@(posedge clk_i) disable iff (!rst_i)
      ready_i |=> !ready_i)
      else $error("ready_o high for more than one cycle");

   // clear drops a pending stall on the same edge
   a_clear_drops_stall : assert property (@(posedge clk_i) disable iff (!rst_i)
      clear_i |=> !stall_i)
      else $error("stall_o still high after a clear command");

endmodule

bind conv_accel_top conv_accel_sva u_sva (
   .clk_i   (clk_i),
   .rst_i   (rst_i),
   .clear_i (any_clear),
   .stall_i (stall_o),
   .ready_i (ready_o)
);

// ==== sim/conv_accel_tb.sv ====
`timescale 1ns/1ns
`include "conv_cfg.svh"

module conv_accel_tb;

   logic                    clk_i;
   logic                    rst_i;
   logic                    hold_i;
   logic                    instr_valid_i;
   logic [31:0]             instr_i;
   logic [`CONV_WORD_W-1:0] rs1_i;
   logic [`CONV_WORD_W-1:0] rs2_i;
   logic                    stall_o;
   logic                    ready_o;
   logic [`CONV_WORD_W-1:0] result_o;

   // reference model of both buffers
   logic [`CONV_WORD_W-1:0] filt_m [`CONV_ENTRIES];
   logic [`CONV_WORD_W-1:0] data_m [`CONV_ENTRIES];
   logic [`CONV_IDX_W-1:0]  fptr;
   logic [`CONV_IDX_W-1:0]  dptr;

   int   errors;
   int   checks;
   int   tests;
   int   err_mark;
   int   k;
   int   latency;
   logic saw_stall;

   conv_accel_top dut0 (
      .clk_i         (clk_i),
      .rst_i         (rst_i),
      .hold_i        (hold_i),
      .instr_valid_i (instr_valid_i),
      .instr_i       (instr_i),
      .rs1_i         (rs1_i),
      .rs2_i         (rs2_i),
      .stall_o       (stall_o),
      .ready_o       (ready_o),
      .result_o      (result_o)
   );

   initial begin
      clk_i = 1'b0;
      forever #4 clk_i = ~clk_i;
   end

   // inputs change and outputs are sampled 1 ns after the edge
   task automatic step;
      @(posedge clk_i);
      #1;
   endtask

   task automatic issue(input conv_pkg::conv_op_e op, input logic [31:0] a,
                        input logic [31:0] b);
      instr_valid_i = 1'b1;
      instr_i       = {4'b0000, op, 18'd0, `CONV_OPCODE};  // funct7 selects the op
      rs1_i         = a;
      rs2_i         = b;
      step();
      instr_valid_i = 1'b0;
   endtask

   task automatic clear_buf(input logic filter);
      if (filter) begin
         issue(conv_pkg::op_filter_clear, '0, '0);
         fptr = '0;
      end else begin
         issue(conv_pkg::op_data_clear, '0, '0);
         dptr = '0;
      end
   endtask

   // random words written as singles or pairs at random
   task automatic load_words(input logic filter, input int count);
      int          left;
      logic [31:0] w0;
      logic [31:0] w1;
      logic        use_pair;
      left = count;
      while (left > 0) begin
         w0       = $urandom;
         w1       = $urandom;
         use_pair = (left >= 2) && ($urandom % 2 == 1);
         if (filter) begin
            filt_m[fptr] = w0;
            if (use_pair) begin
               filt_m[fptr + 4'd1] = w1;
            end
            fptr = fptr + (use_pair ? 4'd2 : 4'd1);
            issue(use_pair ? conv_pkg::op_filter_2 : conv_pkg::op_filter_1, w0, w1);
         end else begin
            data_m[dptr] = w0;
            if (use_pair) begin
               data_m[dptr + 4'd1] = w1;
            end
            dptr = dptr + (use_pair ? 4'd2 : 4'd1);
            issue(use_pair ? conv_pkg::op_data_2 : conv_pkg::op_data_1, w0, w1);
         end
         left = left - (use_pair ? 2 : 1);
      end
   endtask

   // wrapped sum of products over the first count entries
   function automatic logic [31:0] model_sum(input int count);
      logic [31:0] s;
      int          i;
      s = '0;
      for (i = 0; i < count; i++) begin
         s = s + filt_m[`CONV_IDX_W'(i)] * data_m[`CONV_IDX_W'(i)];
      end
      return s;
   endfunction

   task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         $display("MISMATCH at %0t ns: %s, got %h expected %h", $time, what, got, exp);
         errors++;
      end
   endtask

   task automatic wait_ready(input int limit, output int lat, output logic stalled);
      int i;
      lat     = -1;
      stalled = 1'b0;
      i       = 0;
      while (lat < 0 && i < limit) begin
         step();
         i++;
         if (stall_o) begin
            stalled = 1'b1;
         end
         if (ready_o) begin
            lat = i;
         end
      end
      if (lat < 0) begin
         $display("ERROR at %0t ns: ready_o did not pulse within %0d cycles", $time, limit);
         errors++;
      end
   endtask

   task automatic wait_stall(input int limit);
      int i;
      i = 0;
      while (!stall_o && i < limit) begin
         step();
         i++;
      end
      if (!stall_o) begin
         $display("ERROR at %0t ns: stall_o did not rise within %0d cycles", $time, limit);
         errors++;
      end
   endtask

   task automatic end_test(input string name, input int mark);
      tests++;
      if (errors == mark) begin
         $display("test %0d %s: ok", tests, name);
      end else begin
         $display("test %0d %s: %0d errors", tests, name, errors - mark);
      end
   endtask

   initial begin
      void'($urandom(32'hfd0a152c));
      errors        = 0;
      checks        = 0;
      tests         = 0;
      rst_i         = 1'b0;
      hold_i        = 1'b0;
      instr_valid_i = 1'b0;
      instr_i       = '0;
      rs1_i         = '0;
      rs2_i         = '0;
      fptr          = '0;
      dptr          = '0;
      repeat (3) @(posedge clk_i);
      #1;
      rst_i = 1'b1;

      err_mark = errors;
      check("stall_o after reset", 32'(stall_o), 32'd0);
      check("ready_o after reset", 32'(ready_o), 32'd0);
      check("result_o after reset", result_o, 32'd0);
      end_test("reset state", err_mark);

      // loads outpace the engine, so the run arrives before done
      err_mark = errors;
      load_words(1'b1, `CONV_ENTRIES);
      load_words(1'b0, `CONV_ENTRIES);
      issue(conv_pkg::op_run, '0, '0);
      wait_ready(100, latency, saw_stall);
      check("stall seen during full run", 32'(saw_stall), 32'd1);
      check("full convolution result", result_o, model_sum(`CONV_ENTRIES));
      end_test("full convolution", err_mark);

      err_mark = errors;
      issue(conv_pkg::op_run, '0, '0);
      wait_ready(10, latency, saw_stall);
      check("ready latency after done", 32'(latency), 32'd1);
      check("stall seen after done", 32'(saw_stall), 32'd0);
      check("repeated result", result_o, model_sum(`CONV_ENTRIES));
      end_test("repeated run", err_mark);

      err_mark = errors;
      clear_buf(1'b1);
      clear_buf(1'b0);
      k = 1 + $urandom % 15;
      load_words(1'b1, k);
      load_words(1'b0, k);
      repeat (2 * k + 4) step();
      issue(conv_pkg::op_run, '0, '0);
      wait_ready(10, latency, saw_stall);
      check("partial answer latency", 32'(latency), 32'd1);
      check("partial sum", result_o, model_sum(k));
      end_test("partial answer", err_mark);

      // top up the filter, then swap only the data
      err_mark = errors;
      load_words(1'b1, `CONV_ENTRIES - k);
      clear_buf(1'b0);
      load_words(1'b0, `CONV_ENTRIES);
      issue(conv_pkg::op_run, '0, '0);
      wait_ready(100, latency, saw_stall);
      check("result with kept filter", result_o, model_sum(`CONV_ENTRIES));
      end_test("data clear keeps filter", err_mark);

      // the hold outlasts a whole run of the engine
      err_mark = errors;
      clear_buf(1'b1);
      clear_buf(1'b0);
      load_words(1'b1, `CONV_ENTRIES);
      load_words(1'b0, `CONV_ENTRIES);
      issue(conv_pkg::op_run, '0, '0);
      wait_stall(10);
      hold_i = 1'b1;
      repeat (40) begin
         step();
         check("stall_o under hold", 32'(stall_o), 32'd1);
         check("ready_o under hold", 32'(ready_o), 32'd0);
      end
      hold_i = 1'b0;
      wait_ready(100, latency, saw_stall);
      check("result after hold", result_o, model_sum(`CONV_ENTRIES));
      end_test("hold during stall", err_mark);

      // a clear during a stall drops the pending run
      err_mark = errors;
      clear_buf(1'b1);
      clear_buf(1'b0);
      load_words(1'b1, `CONV_ENTRIES);
      load_words(1'b0, `CONV_ENTRIES);
      issue(conv_pkg::op_run, '0, '0);
      wait_stall(10);
      clear_buf(1'b0);
      repeat (4) begin
         step();
         check("stall_o after clear", 32'(stall_o), 32'd0);
         check("ready_o after clear", 32'(ready_o), 32'd0);
      end
      end_test("clear during stall", err_mark);

      $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

// ==== src.f ====
+incdir+include
hdl/conv_pkg.sv
hdl/conv_decoder.sv
hdl/matrix_buffer.sv
hdl/mac_engine.sv
hdl/conv_responder.sv
hdl/conv_accel_top.sv
sim/conv_accel_sva.sv
sim/conv_accel_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= conv_accel_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= All tests passed!
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
